// File: sim.f
+incdir+design
design/ratio_pkg.sv
design/contrast_preproc.sv
design/box_sum_h.sv
design/box_sum_v.sv
design/threshold_regs.sv
design/ratio_divider.sv
design/contrast_ratio_top.sv
tests/tb_clk_gen.sv
tests/tb_contrast_ratio.sv

// File: Bender.yml
package:
  name: contrast_ratio

sources:
  - include_dirs:
      - design
    files:
      - design/ratio_pkg.sv
      - design/contrast_preproc.sv
      - design/box_sum_h.sv
      - design/box_sum_v.sv
      - design/threshold_regs.sv
      - design/ratio_divider.sv
      - design/contrast_ratio_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_contrast_ratio.sv

// File: tests/tb_contrast_ratio.sv
`timescale 1ns/1ns
`include "ratio_macros.svh"

module tb_contrast_ratio;

    localparam int FRAME_PIXELS   = `RATIO_IMAGE_WIDTH * `RATIO_IMAGE_HEIGHT;
    localparam int TIMEOUT_CYCLES = 3 * FRAME_PIXELS * 4 + 200;
    localparam int LATENCY        = 4;

    logic                  clk;
    logic                  rst;
    ratio_pkg::intensity_t rho_plus;
    ratio_pkg::intensity_t rho_minus;
    ratio_pkg::coord_t     col;
    ratio_pkg::coord_t     row;
    logic                  valid_in;
    logic                  cfg_we;
    ratio_pkg::sum_t       cfg_wt;
    ratio_pkg::result_t    result;
    logic                  valid_out;

    ratio_pkg::intensity_t plus_px  [`RATIO_IMAGE_HEIGHT][`RATIO_IMAGE_WIDTH];
    ratio_pkg::intensity_t minus_px [`RATIO_IMAGE_HEIGHT][`RATIO_IMAGE_WIDTH];
    ratio_pkg::result_t    exp_q [$];
    ratio_pkg::sum_t       wt_model;
    ratio_pkg::sum_t       corner_c;
    logic [LATENCY-1:0]    valid_hist;
    int                    n_checks;
    int                    n_errors;
    int                    n_beats;
    int                    cycles;

    tb_clk_gen clk_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    contrast_ratio_top DUT (
        .clk_i        (clk),
        .rst_i        (rst),
        .i_rho_plus_i (rho_plus),
        .i_rho_minus_i(rho_minus),
        .col_i        (col),
        .row_i        (row),
        .valid_i      (valid_in),
        .cfg_we_i     (cfg_we),
        .cfg_wt_i     (cfg_wt),
        .result_o     (result),
        .valid_o      (valid_out)
    );

    // trailing 3x3 sums over the stored frame, then the thresholded Q8 ratio
    function automatic ratio_pkg::result_t ref_result(int r, int c, ratio_pkg::sum_t wt);
        ratio_pkg::result_t res;
        int sv;
        int sw;
        int z;
        int dr;
        int dc;
        sv = 0;
        sw = 0;
        for (dr = 0; dr < 3; dr++) begin
            for (dc = 0; dc < 3; dc++) begin
                if (r - dr >= 0 && c - dc >= 0) begin
                    sv += int'(plus_px[r-dr][c-dc]) - int'(minus_px[r-dr][c-dc]);
                    sw += int'(plus_px[r-dr][c-dc]) + int'(minus_px[r-dr][c-dc]);
                end
            end
        end
        z = 0;
        if (sw != 0 && sw >= int'(wt)) begin
            z = (sv * (1 << `RATIO_FRAC_BITS)) / sw;
        end
        res.z   = ratio_pkg::ratio_t'(z);
        res.c   = ratio_pkg::sum_t'(sw);
        res.col = ratio_pkg::coord_t'(c);
        res.row = ratio_pkg::coord_t'(r);
        return res;
    endfunction

    task automatic check_ratio(string name, ratio_pkg::ratio_t exp, ratio_pkg::ratio_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_conf(string name, ratio_pkg::sum_t exp, ratio_pkg::sum_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_coord(string name, ratio_pkg::coord_t exp, ratio_pkg::coord_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic fill_frame(int max_val);
        int r;
        int c;
        for (r = 0; r < `RATIO_IMAGE_HEIGHT; r++) begin
            for (c = 0; c < `RATIO_IMAGE_WIDTH; c++) begin
                plus_px[r][c]  = 8'($urandom_range(max_val));
                minus_px[r][c] = 8'($urandom_range(max_val));
            end
        end
    endtask

    // raster order with optional idle cycles before each pixel
    task automatic drive_frame(int max_gap);
        int r;
        int c;
        int gap;
        for (r = 0; r < `RATIO_IMAGE_HEIGHT; r++) begin
            for (c = 0; c < `RATIO_IMAGE_WIDTH; c++) begin
                gap = (max_gap > 0) ? $urandom_range(max_gap) : 0;
                repeat (gap) begin
                    @(negedge clk);
                    valid_in = 1'b0;
                end
                @(negedge clk);
                rho_plus  = plus_px[r][c];
                rho_minus = minus_px[r][c];
                col       = ratio_pkg::coord_t'(c);
                row       = ratio_pkg::coord_t'(r);
                valid_in  = 1'b1;
                exp_q.push_back(ref_result(r, c, wt_model));
            end
        end
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    task automatic write_threshold(ratio_pkg::sum_t value);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_wt = value;
        @(negedge clk);
        cfg_we   = 1'b0;
        wt_model = value;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // latency and result compare
    always @(posedge clk) begin
        ratio_pkg::result_t exp;
        if (rst) begin
            valid_hist <= '0;
        end else begin
            if (valid_out !== valid_hist[LATENCY-1]) begin
                n_errors++;
                $display("ERROR t=%0t valid_o expected %0d actual %0d",
                         $time, valid_hist[LATENCY-1], valid_out);
            end
            valid_hist <= {valid_hist[LATENCY-2:0], valid_in};
            if (valid_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("valid_o was high at t=%0t with no beat expected", $time);
                end else begin
                    exp = exp_q.pop_front();
                    n_beats++;
                    check_ratio("result_o.z", exp.z, result.z);
                    check_conf("result_o.c", exp.c, result.c);
                    check_coord("result_o.col", exp.col, result.col);
                    check_coord("result_o.row", exp.row, result.row);
                    if (result.col == 0 && result.row == 0) begin
                        corner_c = result.c;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the output stream never completed", cycles);
            $display("checks %0d errors %0d beats %0d", n_checks, n_errors, n_beats);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rho_plus  = '0;
        rho_minus = '0;
        col       = '0;
        row       = '0;
        valid_in  = 1'b0;
        cfg_we    = 1'b0;
        cfg_wt    = '0;
        n_checks  = 0;
        n_errors  = 0;
        n_beats   = 0;
        cycles    = 0;
        corner_c  = '0;
        wt_model  = ratio_pkg::sum_t'(`RATIO_WT_RESET);
        void'($urandom(90041));

        wait (rst == 1'b0);
        // idle stretch where valid_o must stay low
        repeat (5) @(negedge clk);

        // small intensities so the sums straddle the reset threshold
        fill_frame(3);
        drive_frame(0);
        wait_drained();

        fill_frame(255);
        drive_frame(0);
        wait_drained();
        check_conf("corner c vs own w",
                   ratio_pkg::sum_t'(int'(plus_px[0][0]) + int'(minus_px[0][0])), corner_c);

        drive_frame(3);
        wait_drained();

        write_threshold(ratio_pkg::sum_t'(600));
        drive_frame(0);
        wait_drained();

        // zero threshold so only the w guard prevents division by zero
        write_threshold('0);
        fill_frame(0);
        drive_frame(1);
        wait_drained();

        if (n_beats != 5 * FRAME_PIXELS) begin
            n_errors++;
            $display("only %0d of %0d output beats arrived", n_beats, 5 * FRAME_PIXELS);
        end
        $display("checks %0d errors %0d beats %0d", n_checks, n_errors, n_beats);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held over three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: design/contrast_ratio_top.sv
`timescale 1ns/1ns
`include "ratio_macros.svh"

module contrast_ratio_top (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  ratio_pkg::intensity_t i_rho_plus_i,
    input  ratio_pkg::intensity_t i_rho_minus_i,
    input  ratio_pkg::coord_t     col_i,
    input  ratio_pkg::coord_t     row_i,
    input  logic                  valid_i,

    input  logic                  cfg_we_i,
    input  ratio_pkg::sum_t       cfg_wt_i,

    output ratio_pkg::result_t    result_o,
    output logic                  valid_o
);

    ratio_pkg::vw_beat_t pre_beat_w;
    logic                pre_valid_w;
    ratio_pkg::vw_beat_t boxh_beat_w;
    logic                boxh_valid_w;
    ratio_pkg::vw_beat_t boxv_beat_w;
    logic                boxv_valid_w;
    ratio_pkg::sum_t     w_t_w;

    contrast_preproc preprocessor (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .i_rho_plus_i (i_rho_plus_i),
        .i_rho_minus_i(i_rho_minus_i),
        .col_i        (col_i),
        .row_i        (row_i),
        .valid_i      (valid_i),
        .beat_o       (pre_beat_w),
        .valid_o      (pre_valid_w)
    );

    box_sum_h box_h (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .beat_i (pre_beat_w),
        .valid_i(pre_valid_w),
        .beat_o (boxh_beat_w),
        .valid_o(boxh_valid_w)
    );

    box_sum_v box_v (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .beat_i (boxh_beat_w),
        .valid_i(boxh_valid_w),
        .beat_o (boxv_beat_w),
        .valid_o(boxv_valid_w)
    );

    threshold_regs wt_regs (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .cfg_we_i(cfg_we_i),
        .cfg_wt_i(cfg_wt_i),
        .w_t_o   (w_t_w)
    );

    ratio_divider v_w_divider (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .beat_i  (boxv_beat_w),
        .valid_i (boxv_valid_w),
        .w_t_i   (w_t_w),
        .result_o(result_o),
        .valid_o (valid_o)
    );

endmodule

// File: design/ratio_divider.sv
`timescale 1ns/1ns
`include "ratio_macros.svh"

module ratio_divider (
    input  logic                clk_i,
    input  logic                rst_i,

    input  ratio_pkg::vw_beat_t beat_i,
    input  logic                valid_i,
    input  ratio_pkg::sum_t     w_t_i,

    output ratio_pkg::result_t  result_o,
    output logic                valid_o
);

    logic signed [31:0] num_w;
    logic signed [31:0] den_w;
    logic signed [31:0] quot_w;
    logic               pass_w;
    ratio_pkg::sum_t    v_abs_w;
    ratio_pkg::result_t result_q;
    logic               valid_q;

    // |v| <= w, so the quotient fits in Q8 easily
    always_comb begin
        pass_w  = (beat_i.w != '0) && ($signed(beat_i.w) >= $signed(w_t_i));
        num_w   = 32'($signed(beat_i.v)) <<< `RATIO_FRAC_BITS;
        den_w   = pass_w ? 32'($signed(beat_i.w)) : 32'sd1;
        quot_w  = num_w / den_w;
        v_abs_w = beat_i.v[15] ? -beat_i.v : beat_i.v;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_q.z   <= pass_w ? ratio_pkg::ratio_t'(quot_w[15:0]) : '0;
            result_q.c   <= beat_i.w;
            result_q.col <= beat_i.col;
            result_q.row <= beat_i.row;
        end
    end

    assign result_o = result_q;
    assign valid_o  = valid_q;

    // holds for any mix of plus/minus through the 3x3 sum
    a_v_bounded_by_w: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> $signed(v_abs_w) <= $signed(beat_i.w))
        else $error("ratio_divider: |v| %0d exceeds w %0d", v_abs_w, beat_i.w);

endmodule

// File: design/threshold_regs.sv
`timescale 1ns/1ns
`include "ratio_macros.svh"

module threshold_regs (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            cfg_we_i,
    input  ratio_pkg::sum_t cfg_wt_i,

    output ratio_pkg::sum_t w_t_o
);

    ratio_pkg::sum_t w_t_q;

    // confidence threshold, default out of reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            w_t_q <= ratio_pkg::sum_t'(`RATIO_WT_RESET);
        end else if (cfg_we_i) begin
            w_t_q <= cfg_wt_i;
        end
    end

    assign w_t_o = w_t_q;

endmodule

// File: design/box_sum_v.sv
`timescale 1ns/1ns
`include "ratio_macros.svh"

module box_sum_v (
    input  logic                clk_i,
    input  logic                rst_i,

    input  ratio_pkg::vw_beat_t beat_i,
    input  logic                valid_i,

    output ratio_pkg::vw_beat_t beat_o,
    output logic                valid_o
);

    localparam int COL_BITS = $clog2(`RATIO_IMAGE_WIDTH);

    // row above and two rows above, horizontal sums
    ratio_pkg::sum_t     lb1_v_q [`RATIO_IMAGE_WIDTH];
    ratio_pkg::sum_t     lb1_w_q [`RATIO_IMAGE_WIDTH];
    ratio_pkg::sum_t     lb2_v_q [`RATIO_IMAGE_WIDTH];
    ratio_pkg::sum_t     lb2_w_q [`RATIO_IMAGE_WIDTH];

    logic [COL_BITS-1:0] col_idx_w;
    ratio_pkg::sum_t     up1_v_w;
    ratio_pkg::sum_t     up1_w_w;
    ratio_pkg::sum_t     sum_v_w;
    ratio_pkg::sum_t     sum_w_w;
    ratio_pkg::vw_beat_t beat_q;
    logic                valid_q;

    assign col_idx_w = beat_i.col[COL_BITS-1:0];
    assign up1_v_w   = lb1_v_q[col_idx_w];
    assign up1_w_w   = lb1_w_q[col_idx_w];

    // buffers hold stale data until rows 1 and 2 of this frame
    always_comb begin
        sum_v_w = beat_i.v;
        sum_w_w = beat_i.w;
        if (beat_i.row >= 16'd1) begin
            sum_v_w = sum_v_w + up1_v_w;
            sum_w_w = sum_w_w + up1_w_w;
        end
        if (beat_i.row >= 16'd2) begin
            sum_v_w = sum_v_w + lb2_v_q[col_idx_w];
            sum_w_w = sum_w_w + lb2_w_q[col_idx_w];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // shift this column down by one row
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            lb2_v_q[col_idx_w] <= up1_v_w;
            lb2_w_q[col_idx_w] <= up1_w_w;
            lb1_v_q[col_idx_w] <= beat_i.v;
            lb1_w_q[col_idx_w] <= beat_i.w;
            beat_q.v           <= sum_v_w;
            beat_q.w           <= sum_w_w;
            beat_q.col         <= beat_i.col;
            beat_q.row         <= beat_i.row;
        end
    end

    assign beat_o  = beat_q;
    assign valid_o = valid_q;

    a_row_in_frame: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> beat_i.row < `RATIO_IMAGE_HEIGHT)
        else $error("box_sum_v: row %0d outside frame", beat_i.row);

endmodule

// File: design/box_sum_h.sv
`timescale 1ns/1ns
`include "ratio_macros.svh"

module box_sum_h (
    input  logic                clk_i,
    input  logic                rst_i,

    input  ratio_pkg::vw_beat_t beat_i,
    input  logic                valid_i,

    output ratio_pkg::vw_beat_t beat_o,
    output logic                valid_o
);

    // last two samples of the current row
    ratio_pkg::sum_t     v_d1_q;
    ratio_pkg::sum_t     w_d1_q;
    ratio_pkg::sum_t     v_d2_q;
    ratio_pkg::sum_t     w_d2_q;

    ratio_pkg::sum_t     sum_v_w;
    ratio_pkg::sum_t     sum_w_w;
    ratio_pkg::vw_beat_t beat_q;
    logic                valid_q;

    // predecessors only exist from column 1 and 2 on
    always_comb begin
        sum_v_w = beat_i.v;
        sum_w_w = beat_i.w;
        if (beat_i.col >= 16'd1) begin
            sum_v_w = sum_v_w + v_d1_q;
            sum_w_w = sum_w_w + w_d1_q;
        end
        if (beat_i.col >= 16'd2) begin
            sum_v_w = sum_v_w + v_d2_q;
            sum_w_w = sum_w_w + w_d2_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            v_d2_q     <= v_d1_q;
            w_d2_q     <= w_d1_q;
            v_d1_q     <= beat_i.v;
            w_d1_q     <= beat_i.w;
            beat_q.v   <= sum_v_w;
            beat_q.w   <= sum_w_w;
            beat_q.col <= beat_i.col;
            beat_q.row <= beat_i.row;
        end
    end

    assign beat_o  = beat_q;
    assign valid_o = valid_q;

    a_col_in_frame: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> beat_i.col < `RATIO_IMAGE_WIDTH)
        else $error("box_sum_h: column %0d outside frame", beat_i.col);

endmodule

// File: design/contrast_preproc.sv
`timescale 1ns/1ns

module contrast_preproc (
    input  logic                    clk_i,
    input  logic                    rst_i,

    input  ratio_pkg::intensity_t   i_rho_plus_i,
    input  ratio_pkg::intensity_t   i_rho_minus_i,
    input  ratio_pkg::coord_t       col_i,
    input  ratio_pkg::coord_t       row_i,
    input  logic                    valid_i,

    output ratio_pkg::vw_beat_t     beat_o,
    output logic                    valid_o
);

    ratio_pkg::vw_beat_t beat_q;
    logic                valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // zero-extend both samples before forming difference and sum
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            beat_q.v   <= ratio_pkg::sum_t'({8'd0, i_rho_plus_i})
                        - ratio_pkg::sum_t'({8'd0, i_rho_minus_i});
            beat_q.w   <= ratio_pkg::sum_t'({8'd0, i_rho_plus_i})
                        + ratio_pkg::sum_t'({8'd0, i_rho_minus_i});
            beat_q.col <= col_i;
            beat_q.row <= row_i;
        end
    end

    assign beat_o  = beat_q;
    assign valid_o = valid_q;

endmodule

// File: design/ratio_pkg.sv
package ratio_pkg;

    // raw sensor sample
    typedef logic [7:0] intensity_t;

    // column or row index
    typedef logic [15:0] coord_t;

    // v and w accumulators, w stays non-negative
    typedef logic signed [15:0] sum_t;

    // signed Q8 contrast ratio
    typedef logic signed [15:0] ratio_t;

    typedef struct packed {
        sum_t   v;
        sum_t   w;
        coord_t col;
        coord_t row;
    } vw_beat_t;

    typedef struct packed {
        ratio_t z;
        sum_t   c;
        coord_t col;
        coord_t row;
    } result_t;

endpackage

// File: design/ratio_macros.svh
`ifndef RATIO_MACROS_SVH
`define RATIO_MACROS_SVH

// frame geometry
`define RATIO_IMAGE_WIDTH  8
`define RATIO_IMAGE_HEIGHT 6

// fraction bits of z
`define RATIO_FRAC_BITS 8

// confidence threshold out of reset
`define RATIO_WT_RESET 16

`endif
